//--- Makefile
# Verilator build and run for the triangles display

VERILATOR ?= verilator
TOP       ?= triangles_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "simulation stopped early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/triangles_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// triangle display constants
// 640x480 timing, framebuffer size and palette
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRIANGLES_CONSTS_SVH
`define TRIANGLES_CONSTS_SVH

`define TRI_H_ACTIVE 640  // visible columns
`define TRI_H_FP 16
`define TRI_H_SYNC 96
`define TRI_H_BP 48
`define TRI_H_TOTAL 800  // clocks per line

`define TRI_V_ACTIVE 480  // visible lines
`define TRI_V_FP 10
`define TRI_V_SYNC 2
`define TRI_V_BP 33
`define TRI_V_TOTAL 525  // lines per frame

`define TRI_FB_WIDTH 160
`define TRI_FB_HEIGHT 120
`define TRI_FB_SCALE 4  // screen pixels per framebuffer pixel

`define TRI_PAL_0 12'h000  // black
`define TRI_PAL_1 12'hF80  // orange
`define TRI_PAL_2 12'h0C0  // green
`define TRI_PAL_3 12'h06F  // blue

`endif

//--- source/display_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display types for timing and video out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package display_pkg;

    typedef struct packed {
        logic [9:0] sx;  // column
        logic [9:0] sy;  // line
    } screen_pos_t;

    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;
        logic frame;  // start of frame strobe
        logic line;   // start of line strobe
    } sync_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

//--- source/display_timings.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 display timing generator
// screen position and sync decode from two counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "triangles_consts.svh"

module display_timings (
    input  logic                     clk_pix,
    input  logic                     reset,
    output display_pkg::screen_pos_t pos,
    output display_pkg::sync_t       timing
);

    localparam int hs_start = `TRI_H_ACTIVE + `TRI_H_FP;
    localparam int hs_end = hs_start + `TRI_H_SYNC;
    localparam int vs_start = `TRI_V_ACTIVE + `TRI_V_FP;
    localparam int vs_end = vs_start + `TRI_V_SYNC;

    logic [9:0] sx;  // column counter
    logic [9:0] sy;  // line counter

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == `TRI_H_TOTAL - 1) begin
            sx <= '0;
            sy <= (sy == `TRI_V_TOTAL - 1) ? '0 : sy + 10'd1;  // wrap at end of frame
        end else begin
            sx <= sx + 10'd1;
        end
    end

    // all outputs straight from the counters
    always_comb begin
        pos.sx = sx;
        pos.sy = sy;
        timing.hsync = !(sx >= hs_start && sx < hs_end);
        timing.vsync = !(sy >= vs_start && sy < vs_end);
        timing.de = (sx < `TRI_H_ACTIVE) && (sy < `TRI_V_ACTIVE);
        timing.frame = (sx == 10'd0) && (sy == 10'd0);
        timing.line = (sx == 10'd0);
    end

endmodule

//--- source/framebuffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 160x120 framebuffer with 4x scaled readout
// palette lookup and sync delay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "triangles_consts.svh"

module framebuffer (
    input  logic                     clk_pix,
    input  logic                     reset,
    input  geometry_pkg::fb_write_t  wr,
    input  display_pkg::screen_pos_t pos,
    input  display_pkg::sync_t       timing,
    output display_pkg::sync_t       video_sync,
    output display_pkg::rgb_t        video_rgb
);

    localparam int fb_words = `TRI_FB_WIDTH * `TRI_FB_HEIGHT;
    localparam int addr_w = $clog2(fb_words);

    geometry_pkg::cidx_t mem [fb_words];
    logic [addr_w-1:0]   wr_addr;
    logic [addr_w-1:0]   rd_addr;
    logic                wr_inside;
    geometry_pkg::cidx_t rd_cidx;

    function automatic display_pkg::rgb_t palette(input geometry_pkg::cidx_t c);
        display_pkg::rgb_t rgb;
        case (c)
            2'd1: rgb = `TRI_PAL_1;
            2'd2: rgb = `TRI_PAL_2;
            2'd3: rgb = `TRI_PAL_3;
            default: rgb = `TRI_PAL_0;
        endcase
        return rgb;
    endfunction

    initial begin
        for (int i = 0; i < fb_words; i++) begin
            mem[i] = '0;
        end
    end

    // clip to the framebuffer area
    assign wr_inside = (wr.pos.x >= 0) && (wr.pos.x < `TRI_FB_WIDTH)
                    && (wr.pos.y >= 0) && (wr.pos.y < `TRI_FB_HEIGHT);
    assign wr_addr = addr_w'(wr.pos.y) * addr_w'(`TRI_FB_WIDTH) + addr_w'(wr.pos.x);

    always_ff @(posedge clk_pix) begin
        if (wr.we && wr_inside) begin
            mem[wr_addr] <= wr.colour;
        end
    end

    // blanking reads park on word 0
    assign rd_addr = timing.de
                   ? addr_w'(pos.sy / `TRI_FB_SCALE) * addr_w'(`TRI_FB_WIDTH)
                     + addr_w'(pos.sx / `TRI_FB_SCALE)
                   : '0;
    assign rd_cidx = mem[rd_addr];

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            video_sync <= '{hsync: 1'b1, vsync: 1'b1, default: 1'b0};
            video_rgb <= '0;
        end else begin
            video_sync <= timing;  // one cycle to match the colour
            video_rgb <= timing.de ? palette(rd_cidx) : '0;
        end
    end

endmodule

//--- source/geometry_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drawing types for the rasterizer
// and the framebuffer write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package geometry_pkg;

    typedef logic signed [15:0] coord_t;  // framebuffer coordinate

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef logic [1:0] cidx_t;  // palette index

    typedef struct packed {
        point_t p0;
        point_t p1;
        point_t p2;
        cidx_t  colour;
    } triangle_t;

    // one pixel write per clock
    typedef struct packed {
        logic   we;
        point_t pos;
        cidx_t  colour;
    } fb_write_t;

endpackage

//--- source/shape_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shape decode stage
// steps through the triangle table one triangle per done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module shape_decode (
    input  logic                    clk_pix,
    input  logic                    reset,
    input  logic                    frame,
    input  logic                    done,
    output logic                    start,
    output geometry_pkg::triangle_t triangle,
    output logic                    complete
);

    typedef enum logic [1:0] {st_idle, st_issue, st_wait, st_finished} state_t;

    localparam logic [1:0] last_shape = 2'd2;

    state_t     state;
    logic [1:0] shape_idx;

    function automatic geometry_pkg::point_t pt(input int x, input int y);
        geometry_pkg::point_t p;
        p.x = geometry_pkg::coord_t'(x);
        p.y = geometry_pkg::coord_t'(y);
        return p;
    endfunction

    // fixed table of outlines
    function automatic geometry_pkg::triangle_t shape_entry(input logic [1:0] idx);
        geometry_pkg::triangle_t t;
        case (idx)
            2'd0: begin
                t.p0 = pt(10, 30);
                t.p1 = pt(30, 90);
                t.p2 = pt(65, 45);
                t.colour = 2'd1;  // orange
            end
            2'd1: begin
                t.p0 = pt(35, 100);
                t.p1 = pt(120, 50);
                t.p2 = pt(85, 5);
                t.colour = 2'd2;  // green
            end
            default: begin
                t.p0 = pt(30, 15);
                t.p1 = pt(150, 40);
                t.p2 = pt(80, 110);
                t.colour = 2'd3;  // blue
            end
        endcase
        return t;
    endfunction

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= st_idle;
            shape_idx <= '0;
        end else begin
            case (state)
                st_idle: if (frame) state <= st_issue;
                st_issue: state <= st_wait;
                st_wait: begin
                    if (done) begin
                        if (shape_idx == last_shape) begin
                            state <= st_finished;
                        end else begin
                            shape_idx <= shape_idx + 2'd1;
                            state <= st_issue;
                        end
                    end
                end
                default: state <= st_finished;  // held until reset
            endcase
        end
    end

    // triangle is ready by the issue cycle
    always_ff @(posedge clk_pix) begin
        if (state == st_idle) begin
            triangle <= shape_entry(2'd0);
        end else if (state == st_wait && done) begin
            triangle <= shape_entry(shape_idx + 2'd1);
        end
    end

    assign start = (state == st_issue);
    assign complete = (state == st_finished);

endmodule

//--- source/triangle_draw.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// triangle outline rasterizer
// walks the three edges one pixel per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module triangle_draw (
    input  logic                    clk_pix,
    input  logic                    reset,
    input  logic                    start,
    input  geometry_pkg::triangle_t triangle,
    output geometry_pkg::fb_write_t wr,
    output logic                    busy,
    output logic                    done
);

    // state of one line walk
    typedef struct packed {
        geometry_pkg::point_t pos;   // pixel written this cycle
        geometry_pkg::point_t stop;  // far end of the edge
        geometry_pkg::coord_t dx;    // never negative
        geometry_pkg::coord_t dy;    // never positive
        geometry_pkg::coord_t err;
        logic                 left;  // x steps down
        logic                 up;    // y steps down
    } walk_t;

    geometry_pkg::triangle_t held;
    walk_t                   walk;
    logic [1:0]              edge_idx;  // 0 p0-p1, 1 p1-p2, 2 p2-p0
    geometry_pkg::point_t    seg_a;
    geometry_pkg::point_t    seg_b;
    logic                    edge_end;

    function automatic walk_t walk_init(
        input geometry_pkg::point_t a,
        input geometry_pkg::point_t b
    );
        walk_t w;
        w.pos = a;
        w.stop = b;
        w.left = b.x < a.x;
        w.up = b.y < a.y;
        w.dx = w.left ? a.x - b.x : b.x - a.x;
        w.dy = w.up ? b.y - a.y : a.y - b.y;
        w.err = w.dx + w.dy;
        return w;
    endfunction

    function automatic walk_t walk_step(input walk_t w);
        walk_t                n;
        geometry_pkg::coord_t e2;
        n = w;
        e2 = w.err <<< 1;
        if (e2 >= w.dy) begin
            n.err = n.err + w.dy;
            n.pos.x = w.left ? w.pos.x - 16'sd1 : w.pos.x + 16'sd1;
        end
        if (e2 <= w.dx) begin
            n.err = n.err + w.dx;
            n.pos.y = w.up ? w.pos.y - 16'sd1 : w.pos.y + 16'sd1;
        end
        return n;
    endfunction

    assign edge_end = (walk.pos == walk.stop);

    // endpoints of the edge after the current one
    always_comb begin
        if (edge_idx == 2'd0) begin
            seg_a = held.p1;
            seg_b = held.p2;
        end else begin
            seg_a = held.p2;
            seg_b = held.p0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            edge_idx <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    edge_idx <= 2'd0;
                end
            end else if (edge_end) begin
                if (edge_idx == 2'd2) begin  // last pixel of the outline
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    edge_idx <= edge_idx + 2'd1;
                end
            end
        end
    end

    // next edge starts on the shared vertex so there is no idle cycle
    always_ff @(posedge clk_pix) begin
        if (!busy && start) begin
            held <= triangle;
            walk <= walk_init(triangle.p0, triangle.p1);
        end else if (busy) begin
            walk <= edge_end ? walk_init(seg_a, seg_b) : walk_step(walk);
        end
    end

    always_comb begin
        wr.we = busy;
        wr.pos = walk.pos;
        wr.colour = held.colour;
    end

endmodule

//--- source/triangles_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// triangles display top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module triangles_top (
    input  logic               clk_pix,
    input  logic               reset,
    output display_pkg::sync_t video_sync,
    output display_pkg::rgb_t  video_rgb,
    output logic               draw_busy,
    output logic               draw_complete
);

    display_pkg::screen_pos_t scr_pos;
    display_pkg::sync_t       scr_timing;
    geometry_pkg::triangle_t  shape;       // decode to execute
    geometry_pkg::fb_write_t  fb_wr;       // execute to result
    logic                     draw_start;
    logic                     draw_done;

    display_timings timings0 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .pos     (scr_pos),
        .timing  (scr_timing)
    );

    shape_decode decode0 (
        .clk_pix  (clk_pix),
        .reset    (reset),
        .frame    (scr_timing.frame),
        .done     (draw_done),
        .start    (draw_start),
        .triangle (shape),
        .complete (draw_complete)
    );

    triangle_draw draw0 (
        .clk_pix  (clk_pix),
        .reset    (reset),
        .start    (draw_start),
        .triangle (shape),
        .wr       (fb_wr),
        .busy     (draw_busy),
        .done     (draw_done)
    );

    framebuffer fb0 (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .wr         (fb_wr),
        .pos        (scr_pos),
        .timing     (scr_timing),
        .video_sync (video_sync),
        .video_rgb  (video_rgb)
    );

endmodule

//--- verif/triangles_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the triangles top ports
// reset values, line timing and blanking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "triangles_consts.svh"

module triangles_assertions (
    input logic               clk_pix,
    input logic               reset,
    input display_pkg::sync_t video_sync,
    input display_pkg::rgb_t  video_rgb,
    input logic               draw_busy,
    input logic               draw_complete
);

    int   hs_low_len;  // low cycles so far in this hsync pulse
    int   hs_gap;      // cycles since the last hsync fall
    logic hs_prev;
    logic hs_seen;     // gap valid after the first fall

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hs_low_len <= 0;
            hs_gap <= 0;
            hs_prev <= 1'b1;
            hs_seen <= 1'b0;
        end else begin
            hs_prev <= video_sync.hsync;
            hs_low_len <= video_sync.hsync ? 0 : hs_low_len + 1;
            if (hs_prev && !video_sync.hsync) begin
                hs_gap <= 1;
                hs_seen <= 1'b1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
        end
    end

    reset_values: assert property (@(posedge clk_pix)
        reset |=> (video_sync.hsync && video_sync.vsync && !video_sync.de
                   && video_rgb == '0 && !draw_busy && !draw_complete))
        else $error("outputs not at their reset values");

    hsync_width: assert property (@(posedge clk_pix) disable iff (reset)
        (!hs_prev && video_sync.hsync) |-> hs_low_len == `TRI_H_SYNC)
        else $error("hsync low for %0d cycles", hs_low_len);

    hsync_period: assert property (@(posedge clk_pix) disable iff (reset)
        (hs_prev && !video_sync.hsync && hs_seen) |-> hs_gap == `TRI_H_TOTAL)
        else $error("hsync falls %0d cycles apart", hs_gap);

    blank_black: assert property (@(posedge clk_pix) disable iff (reset)
        !video_sync.de |-> video_rgb == '0)
        else $error("colour output outside the active area");

    // drawing never restarts once the table is done
    idle_after_complete: assert property (@(posedge clk_pix) disable iff (reset)
        draw_complete |-> !draw_busy)
        else $error("rasterizer busy after drawing completed");

endmodule

bind triangles_top triangles_assertions checks0 (
    .clk_pix       (clk_pix),
    .reset         (reset),
    .video_sync    (video_sync),
    .video_rgb     (video_rgb),
    .draw_busy     (draw_busy),
    .draw_complete (draw_complete)
);

//--- verif/triangles_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the triangles display
// frame timing and drawn pixel checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "triangles_consts.svh"

module triangles_tb;

    localparam int clk_period = 20;
    localparam int frame_cycles = `TRI_H_TOTAL * `TRI_V_TOTAL;
    localparam int run_frames = 4;  // watchdog budget
    localparam int num_probes = 4;

    logic               clk_pix;
    logic               reset;
    display_pkg::sync_t video_sync;
    display_pkg::rgb_t  video_rgb;
    logic               draw_busy;
    logic               draw_complete;

    int checks;
    int errors;
    int frame_count;
    int sx;  // position of the pixel now on the outputs
    int sy;
    int line_pulses;
    int de_lines;
    int de_in_line;
    int vs_lines;
    int vs_cycles;

    // screen origin then the scaled triangle 2 vertices
    int probe_x [num_probes] = '{0, 30 * `TRI_FB_SCALE, 150 * `TRI_FB_SCALE,
                                 80 * `TRI_FB_SCALE};
    int probe_y [num_probes] = '{0, 15 * `TRI_FB_SCALE, 40 * `TRI_FB_SCALE,
                                 110 * `TRI_FB_SCALE};
    logic [11:0] probe_rgb [num_probes] = '{`TRI_PAL_0, `TRI_PAL_3, `TRI_PAL_3, `TRI_PAL_3};
    logic        probe_seen [num_probes];

    triangles_top dut0 (
        .clk_pix       (clk_pix),
        .reset         (reset),
        .video_sync    (video_sync),
        .video_rgb     (video_rgb),
        .draw_busy     (draw_busy),
        .draw_complete (draw_complete)
    );

    initial clk_pix = 1'b0;
    always #(clk_period / 2) clk_pix = ~clk_pix;

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    task automatic check_equal(input int got, input int want, input string what);
        checks++;
        if (got != want) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, want));
        end
    endtask

    task automatic close_line();
        if (de_in_line != 0) begin  // active line
            de_lines++;
            check_equal(de_in_line, `TRI_H_ACTIVE, "de cycles in a line");
        end
        de_in_line = 0;
    endtask

    task automatic close_frame();
        check_equal(line_pulses, `TRI_V_TOTAL, "line pulses in a frame");
        check_equal(de_lines, `TRI_V_ACTIVE, "lines with de");
        check_equal(vs_lines, `TRI_V_SYNC, "lines in vsync");
        check_equal(vs_cycles, `TRI_V_SYNC * `TRI_H_TOTAL, "vsync low cycles");
        line_pulses = 0;
        de_lines = 0;
        vs_lines = 0;
        vs_cycles = 0;
    endtask

    task automatic probe_pixels();
        logic [11:0] rgb_now;
        rgb_now = video_rgb;
        for (int i = 0; i < num_probes; i++) begin
            if (sx == probe_x[i] && sy == probe_y[i]) begin
                probe_seen[i] = 1'b1;
                checks++;
                if (rgb_now != probe_rgb[i]) begin
                    report_mismatch($sformatf("pixel (%0d,%0d) is %03h, expected %03h",
                                              sx, sy, rgb_now, probe_rgb[i]));
                end
            end
        end
    endtask

    // called at each falling edge where the outputs are settled
    task automatic track_cycle();
        if (video_sync.frame) begin
            close_line();
            if (frame_count > 0) close_frame();
            frame_count++;
            sx = 0;
            sy = 0;
            if (frame_count == 3) begin
                checks++;
                if (!draw_complete) report_mismatch("draw_complete still low at frame 3");
            end
        end else if (sx == `TRI_H_TOTAL - 1) begin
            sx = 0;
            sy++;
        end else begin
            sx++;
        end
        if (video_sync.line && !video_sync.frame) close_line();
        if (video_sync.line) begin
            line_pulses++;
            if (!video_sync.vsync) vs_lines++;
        end
        if (video_sync.de) de_in_line++;
        if (!video_sync.vsync) vs_cycles++;
        if (frame_count == 3) probe_pixels();
    endtask

    initial begin
        reset = 1'b1;
        checks = 0;
        errors = 0;
        frame_count = 0;
        sx = 0;
        sy = 0;
        line_pulses = 0;
        de_lines = 0;
        de_in_line = 0;
        vs_lines = 0;
        vs_cycles = 0;
        for (int i = 0; i < num_probes; i++) begin
            probe_seen[i] = 1'b0;
        end
        repeat (2) @(posedge clk_pix);
        #1 reset = 1'b0;
        while (frame_count < 4) begin  // three whole frames
            @(negedge clk_pix);
            track_cycle();
        end
        for (int i = 0; i < num_probes; i++) begin
            if (!probe_seen[i]) begin
                errors++;
                $display("pixel at (%0d,%0d) was never sampled", probe_x[i], probe_y[i]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(run_frames * frame_cycles * clk_period);
        errors++;
        $display("run timed out after %0d frames of simulated time", run_frames);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
source/geometry_pkg.sv
source/display_pkg.sv
source/display_timings.sv
source/shape_decode.sv
source/triangle_draw.sv
source/framebuffer.sv
source/triangles_top.sv
verif/triangles_assertions.sv
verif/triangles_tb.sv
